/* dwnld_remap.sv */
`timescale 1ns/10ps
`default_nettype none

module dwnld_remap
    import rom_pkg::*;
(
    input  wire                   clk,
    input  wire                   arst_n,
    input  wire                   downloading,
    input  wire  [ioctl_aw-1:0]   ioctl_addr,
    input  wire  [7:0]            ioctl_dout,
    input  wire                   ioctl_wr,
    input  wire                   swab,
    output logic [sdram_aw-1:0]   prog_addr,
    output logic [7:0]            prog_data,
    output logic [1:0]            prog_mask,  // Active low
    output logic                  prog_we,
    output logic [prom_count-1:0] prom_we
);

    logic                  accept;
    logic [ioctl_aw-1:0]   raw_addr;   // Header stripped
    logic                  in_map2;
    logic                  in_scr2;
    logic                  in_obj;
    logic                  in_prom;
    logic [ioctl_aw-1:0]   byte_addr;  // After byte level reorder
    logic [sdram_aw-1:0]   word_raw;
    logic [sdram_aw-1:0]   word_addr;  // After word level reorder
    logic                  lane;
    logic [prom_count-1:0] prom_hit;

    assign accept   = downloading && ioctl_wr && (ioctl_addr >= header_len);
    assign raw_addr = ioctl_addr - header_len;

    // Region decode on the stripped address
    assign in_map2 = (raw_addr >= map2_start) && (raw_addr < scr2_start);
    assign in_scr2 = (raw_addr >= scr2_start) && (raw_addr < obj_start);
    assign in_obj  = (raw_addr >= obj_start)  && (raw_addr < prom_start);
    assign in_prom = raw_addr >= prom_start;

    // Byte reorder so that tile rows land in consecutive words
    always_comb begin
        if (in_map2) begin
            byte_addr = {raw_addr[24:7], raw_addr[5:0], raw_addr[6]};
        end else if (in_scr2) begin
            byte_addr = {raw_addr[24:8], raw_addr[5:1], raw_addr[7:6], raw_addr[0]};
        end else begin
            byte_addr = raw_addr;
        end
    end

    assign word_raw = byte_addr[sdram_aw:1];

    // Sprite words are reordered after halving
    always_comb begin
        if (in_obj) begin
            word_addr = {word_raw[21:6], word_raw[4:1], word_raw[5], word_raw[0]};
        end else begin
            word_addr = word_raw;
        end
    end

    assign lane = byte_addr[0] ^ swab;

    // PROM select from word address bits 11:8
    always_comb begin
        prom_hit = '0;
        if (in_prom) begin
            for (int i = 0; i < prom_count; i++) begin
                if (word_addr[11:8] == 4'(i)) begin
                    prom_hit[i] = 1'b1;
                end
            end
        end
    end

    // Strobes
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            prog_we <= 1'b0;
            prom_we <= '0;
        end else begin
            prog_we <= accept;
            prom_we <= accept ? prom_hit : '0;
        end
    end

    // Write payload, valid with prog_we
    always_ff @(posedge clk) begin
        if (accept) begin
            prog_addr <= word_addr;
            prog_data <= ioctl_dout;
            prog_mask <= lane ? 2'b01 : 2'b10;  // Lane 0 writes the low byte
        end
    end

endmodule

`default_nettype wire

/* header_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module header_regs
    import rom_pkg::*;
(
    input  wire                 clk,
    input  wire                 arst_n,
    input  wire                 downloading,
    input  wire  [ioctl_aw-1:0] ioctl_addr,
    input  wire  [7:0]          ioctl_dout,
    input  wire                 ioctl_wr,
    output logic                swab,      // Byte order of the ROM image
    output logic [7:0]          game_cfg
);

    logic hdr_wr;
    logic hdr_byte;  // Which header byte is on the bus

    // Header bytes sit at the very start of the stream
    assign hdr_wr   = downloading && ioctl_wr && (ioctl_addr < header_len);
    assign hdr_byte = ioctl_addr[0];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            swab     <= 1'b0;
            game_cfg <= 8'd0;
        end else if (hdr_wr) begin
            if (hdr_byte) begin
                game_cfg <= ioctl_dout;  // Byte 1
            end else begin
                swab <= ioctl_dout[0];   // Byte 0, only bit 0 matters
            end
        end
    end

    // The values stay put until the next download's header rewrites them

endmodule

`default_nettype wire

/* project.f */
rom_pkg.sv
header_regs.sv
dwnld_remap.sv
rom_slot_arb.sv
rom_sys_top.sv
rom_sys_props.sv
rom_sys_tb.sv

/* rom_pkg.sv */
`default_nettype none

package rom_pkg;

    // Bus widths
    localparam int ioctl_aw = 25;  // Loader byte address
    localparam int sdram_aw = 22;  // SDRAM word address

    // Word address width seen by each fetch client
    localparam int main_aw = 14;
    localparam int char_aw = 13;
    localparam int scr_aw  = 11;

    // Bytes at the start of the download that never reach SDRAM
    localparam logic [ioctl_aw-1:0] header_len = 25'd2;

    // Region map, byte addresses after the header is stripped
    localparam logic [ioctl_aw-1:0] main_start = 25'h000_0000;
    localparam logic [ioctl_aw-1:0] char_start = 25'h000_8000;
    localparam logic [ioctl_aw-1:0] map2_start = 25'h000_c000;
    localparam logic [ioctl_aw-1:0] scr2_start = 25'h000_d000;
    localparam logic [ioctl_aw-1:0] obj_start  = 25'h000_e000;
    localparam logic [ioctl_aw-1:0] prom_start = 25'h000_f000;

    // Word offsets added by the fetch arbiter
    localparam logic [sdram_aw-1:0] main_offset = sdram_aw'(main_start >> 1);
    localparam logic [sdram_aw-1:0] char_offset = sdram_aw'(char_start >> 1);
    localparam logic [sdram_aw-1:0] scr_offset  = sdram_aw'(map2_start >> 1); // Scroll map data

    localparam int prom_count = 12;  // One write strobe per PROM

    // Fetch slots, lowest index wins
    localparam int slot_count = 3;

    localparam logic [1:0] slot_main = 2'd0;
    localparam logic [1:0] slot_char = 2'd1;
    localparam logic [1:0] slot_scr  = 2'd2;

    // Fetch arbiter states
    typedef enum logic [1:0] {
        arb_idle      = 2'd0,
        arb_wait_ack  = 2'd1,  // Request up, waiting for SDRAM
        arb_wait_data = 2'd2   // Ack seen, waiting for the word
    } arb_state_t;

endpackage

`default_nettype wire

/* rom_slot_arb.sv */
`timescale 1ns/10ps
`default_nettype none

module rom_slot_arb
    import rom_pkg::*;
(
    input  wire                 clk,
    input  wire                 arst_n,
    input  wire                 downloading,
    // Main CPU slot
    input  wire                 main_cs,
    input  wire  [main_aw-1:0]  main_addr,
    output logic                main_ok,
    output logic [15:0]         main_dout,
    // Char slot
    input  wire                 char_cs,
    input  wire  [char_aw-1:0]  char_addr,
    output logic                char_ok,
    output logic [15:0]         char_dout,
    // Scroll slot
    input  wire                 scr_cs,
    input  wire  [scr_aw-1:0]   scr_addr,
    output logic                scr_ok,
    output logic [15:0]         scr_dout,
    // SDRAM read port
    output logic                sdram_req,
    output logic [sdram_aw-1:0] sdram_addr,
    input  wire                 sdram_ack,
    input  wire                 data_rdy,
    input  wire  [15:0]         data_read
);

    arb_state_t state;

    logic [slot_count-1:0] valid;
    logic [1:0]            cur_slot;  // Slot being fetched
    logic [main_aw-1:0]    main_tag;
    logic [char_aw-1:0]    char_tag;
    logic [scr_aw-1:0]     scr_tag;
    logic                  main_hit;
    logic                  char_hit;
    logic                  scr_hit;
    logic                  launch;
    logic [1:0]            pick;

    assign main_hit = valid[slot_main] && (main_tag == main_addr);
    assign char_hit = valid[slot_char] && (char_tag == char_addr);
    assign scr_hit  = valid[slot_scr]  && (scr_tag == scr_addr);

    assign main_ok = main_cs && main_hit;
    assign char_ok = char_cs && char_hit;
    assign scr_ok  = scr_cs  && scr_hit;

    // Fixed priority among the slots that miss
    always_comb begin
        launch = 1'b0;
        pick   = slot_main;
        if (state == arb_idle && !downloading) begin
            if (main_cs && !main_hit) begin
                launch = 1'b1;
                pick   = slot_main;
            end else if (char_cs && !char_hit) begin
                launch = 1'b1;
                pick   = slot_char;
            end else if (scr_cs && !scr_hit) begin
                launch = 1'b1;
                pick   = slot_scr;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= arb_idle;
            sdram_req <= 1'b0;
            cur_slot  <= slot_main;
            valid     <= '0;
        end else begin
            case (state)
                arb_idle: begin
                    if (launch) begin
                        cur_slot    <= pick;
                        valid[pick] <= 1'b0;  // Tag is rewritten below
                        sdram_req   <= 1'b1;
                        state       <= arb_wait_ack;
                    end
                end
                arb_wait_ack: begin
                    if (sdram_ack) begin
                        sdram_req <= 1'b0;
                        state     <= arb_wait_data;
                    end
                end
                arb_wait_data: begin
                    if (data_rdy) begin
                        valid[cur_slot] <= 1'b1;
                        state           <= arb_idle;
                    end
                end
                default: state <= arb_idle;
            endcase
            // A new download makes every cached word stale
            if (downloading) begin
                valid <= '0;
            end
        end
    end

    // Tags, SDRAM address and cached words
    always_ff @(posedge clk) begin
        if (launch) begin
            case (pick)
                slot_main: begin
                    main_tag   <= main_addr;
                    sdram_addr <= main_offset + sdram_aw'(main_addr);
                end
                slot_char: begin
                    char_tag   <= char_addr;
                    sdram_addr <= char_offset + sdram_aw'(char_addr);
                end
                slot_scr: begin
                    scr_tag    <= scr_addr;
                    sdram_addr <= scr_offset + sdram_aw'(scr_addr);
                end
                default: ;
            endcase
        end
        if (state == arb_wait_data && data_rdy) begin
            case (cur_slot)
                slot_main: main_dout <= data_read;
                slot_char: char_dout <= data_read;
                slot_scr:  scr_dout  <= data_read;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

/* rom_sys_props.sv */
`timescale 1ns/10ps
`default_nettype none

module rom_sys_props
    import rom_pkg::*;
(
    input wire                  clk,
    input wire                  arst_n,
    input wire                  downloading,
    input wire                  sdram_req,
    input wire                  sdram_ack,
    input wire                  prog_we,
    input wire [prom_count-1:0] prom_we
);

    int assert_fails = 0;  // Read back by the testbench at the end

    req_idle_in_download: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(sdram_req) |-> !$past(downloading))
        else begin $error("sdram_req rose during a download"); assert_fails++; end

    req_held_to_ack: assert property (@(posedge clk) disable iff (!arst_n)
        sdram_req && !sdram_ack |=> sdram_req)
        else begin $error("sdram_req dropped before sdram_ack"); assert_fails++; end

    prog_we_single: assert property (@(posedge clk) disable iff (!arst_n)
        prog_we |=> !prog_we)
        else begin $error("prog_we longer than one cycle"); assert_fails++; end

    prom_we_onehot: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0(prom_we) && (prom_we == '0 || prog_we))
        else begin $error("prom_we not one-hot with prog_we"); assert_fails++; end

endmodule

bind rom_sys_top rom_sys_props i_props (.*);

`default_nettype wire

/* rom_sys_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module rom_sys_tb
    import rom_pkg::*;
();

    localparam int dl_bytes     = 120;  // Payload bytes per download
    localparam int fetch_rounds = 60;
    localparam int cycle_limit  = 2 * 2 * (2 * (dl_bytes + 2) + 4)
                                + 40 * (3 * 2 * fetch_rounds + 8);

    logic                  clk;
    logic                  arst_n;
    logic                  downloading;
    logic [ioctl_aw-1:0]   ioctl_addr;
    logic [7:0]            ioctl_dout;
    logic                  ioctl_wr;
    logic [sdram_aw-1:0]   prog_addr;
    logic [7:0]            prog_data;
    logic [1:0]            prog_mask;
    logic                  prog_we;
    logic [prom_count-1:0] prom_we;
    logic [7:0]            game_cfg;
    logic                  main_cs, char_cs, scr_cs;
    logic                  main_ok, char_ok, scr_ok;
    logic [main_aw-1:0]    main_addr;
    logic [char_aw-1:0]    char_addr;
    logic [scr_aw-1:0]     scr_addr;
    logic [15:0]           main_dout, char_dout, scr_dout;
    logic                  sdram_req, sdram_ack, data_rdy;
    logic [sdram_aw-1:0]   sdram_addr;
    logic [15:0]           data_read;

    logic [15:0] sdram_mem [0:65535];  // Written through prog_*
    logic [15:0] ref_mem [0:65535];    // Written by the model
    logic [31:0] stim_lfsr = 32'h964b_5eaf;
    logic [31:0] mem_lfsr  = 32'h964b_5eaf;
    logic [15:0] rd_addr;
    int          cycles;
    int          req_count;
    logic        req_prev;
    logic [2:0]  slot_en;  // Bit 0 main, bit 1 char, bit 2 scroll
    logic [6:0]  main_a, char_a, scr_a;

    rom_sys_top i_rom_sys_top (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // Taps 32 22 2 1
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            stim_lfsr = lfsr_step(stim_lfsr);
            v = {v[30:0], stim_lfsr[0]};
        end
        return v;
    endfunction

    // SDRAM response delay of 1 to 4 cycles, own stream
    function automatic int rand_delay();
        logic [1:0] d;
        for (int i = 0; i < 2; i++) begin
            mem_lfsr = lfsr_step(mem_lfsr);
            d = {d[0], mem_lfsr[0]};
        end
        return int'(d) + 1;
    endfunction

    function automatic logic [15:0] ref_word(input logic [ioctl_aw-1:0] start,
                                             input logic [6:0] a);
        return ref_mem[16'((start >> 1) + a)];
    endfunction

    task automatic compare_value(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
            $display("TEST FAILED");
            $fatal(1, "Mismatch on %s", what);
        end
    endtask

    // One loader byte, then the write it must produce
    task automatic send_byte(input logic [ioctl_aw-1:0] addr, input logic [7:0] data,
                             input logic swab_bit);
        logic [ioctl_aw-1:0]   raw;
        logic [ioctl_aw-1:0]   b;
        logic [sdram_aw-1:0]   w;
        logic                  lane;
        logic [prom_count-1:0] prom_exp;
        raw = addr - header_len;
        b   = raw;
        if (raw >= map2_start && raw < scr2_start) begin  // Bits 6:0 rotated left
            b = (raw & ~25'h7f) | ((raw << 1) & 25'h7e) | ((raw >> 6) & 25'h1);
        end else if (raw >= scr2_start && raw < obj_start) begin
            b = (raw & ~25'hff) | ((raw << 2) & 25'hf8) | ((raw >> 5) & 25'h6) | (raw & 25'h1);
        end
        w = sdram_aw'(b >> 1);
        if (raw >= obj_start && raw < prom_start) begin
            w = (w & ~22'h3f) | ((w << 1) & 22'h3c) | ((w >> 4) & 22'h2) | (w & 22'h1);
        end
        lane     = b[0] ^ swab_bit;
        prom_exp = '0;
        if (raw >= prom_start && w[11:8] < prom_count) begin
            prom_exp[w[11:8]] = 1'b1;
        end
        @(posedge clk);
        ioctl_addr <= addr;
        ioctl_dout <= data;
        ioctl_wr   <= 1'b1;
        @(posedge clk);
        ioctl_wr <= 1'b0;
        @(negedge clk);
        if (addr < header_len) begin
            compare_value("prog_we after header byte", prog_we, 0);
            compare_value("prom_we after header byte", prom_we, 0);
        end else begin
            compare_value("prog_we", prog_we, 1);
            compare_value("prog_addr", prog_addr, w);
            compare_value("prog_data", prog_data, data);
            compare_value("prog_mask", prog_mask, lane ? 2'b01 : 2'b10);
            compare_value("prom_we", prom_we, prom_exp);
            if (lane) ref_mem[w[15:0]][15:8] = data;
            else ref_mem[w[15:0]][7:0] = data;
        end
    endtask

    task automatic run_download(input logic swab_bit);
        logic [7:0]          cfg;
        logic [ioctl_aw-1:0] raw;
        cfg = 8'(rand_bits(8));
        @(posedge clk);
        downloading <= 1'b1;
        @(posedge clk);
        @(negedge clk);
        compare_value("ok while downloading", {scr_ok, char_ok, main_ok}, 0);
        send_byte(0, {7'(rand_bits(7)), swab_bit}, swab_bit);
        send_byte(1, cfg, swab_bit);
        repeat (dl_bytes) begin
            case (3'(rand_bits(3)))
                3'd1:       raw = char_start + 25'(rand_bits(8));
                3'd2:       raw = map2_start + 25'(rand_bits(8));
                3'd3:       raw = scr2_start + 25'(rand_bits(8));
                3'd4:       raw = obj_start + 25'(rand_bits(8));
                3'd5, 3'd6: raw = prom_start + 25'(rand_bits(13));  // Reaches all PROM bits
                default:    raw = main_start + 25'(rand_bits(8));
            endcase
            send_byte(raw + header_len, 8'(rand_bits(8)), swab_bit);
        end
        @(posedge clk);
        downloading <= 1'b0;
        @(negedge clk);
        compare_value("game_cfg", game_cfg, cfg);
    endtask

    task automatic settle_slots();
        @(negedge clk);
        while ({scr_ok, char_ok, main_ok} != slot_en) @(negedge clk);
        if (slot_en[0]) compare_value("main_dout", main_dout, ref_word(main_start, main_a));
        if (slot_en[1]) compare_value("char_dout", char_dout, ref_word(char_start, char_a));
        if (slot_en[2]) compare_value("scr_dout", scr_dout, ref_word(map2_start, scr_a));
    endtask

    task automatic fetch_round(input logic [2:0] en);
        slot_en = en;
        main_a  = 7'(rand_bits(7));
        char_a  = 7'(rand_bits(7));
        scr_a   = 7'(rand_bits(7));
        @(posedge clk);
        main_cs   <= en[0];
        char_cs   <= en[1];
        scr_cs    <= en[2];
        main_addr <= main_aw'(main_a);
        char_addr <= char_aw'(char_a);
        scr_addr  <= scr_aw'(scr_a);
        settle_slots();
    endtask

    task automatic cache_check();
        int reqs;
        fetch_round(3'b111);
        reqs = req_count;
        repeat (8) begin
            @(negedge clk);
            compare_value("ok on cache hit", {scr_ok, char_ok, main_ok}, 3'b111);
        end
        compare_value("sdram_req count on cache hit", req_count, reqs);
        main_a = main_a ^ 7'h1;
        @(posedge clk);
        main_addr <= main_aw'(main_a);
        @(negedge clk);
        compare_value("main_ok after address change", main_ok, 0);
        settle_slots();
    endtask

    // SDRAM read side
    initial begin
        forever begin
            @(posedge clk);
            if (sdram_req) begin
                rd_addr = sdram_addr[15:0];
                repeat (rand_delay() - 1) @(posedge clk);
                sdram_ack <= 1'b1;
                @(posedge clk);
                sdram_ack <= 1'b0;
                repeat (rand_delay() - 1) @(posedge clk);
                data_read <= sdram_mem[rd_addr];
                data_rdy  <= 1'b1;
                @(posedge clk);
                data_rdy <= 1'b0;
            end
        end
    end

    // SDRAM write side, request counter and run limit
    always @(posedge clk) begin
        if (prog_we && !prog_mask[0]) sdram_mem[prog_addr[15:0]][7:0] <= prog_data;
        if (prog_we && !prog_mask[1]) sdram_mem[prog_addr[15:0]][15:8] <= prog_data;
        if (sdram_req && !req_prev) req_count <= req_count + 1;
        req_prev <= sdram_req;
        cycles   <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Run did not finish within %0d cycles", cycle_limit);
            $display("TEST FAILED");
            $fatal(1, "Timeout");
        end
    end

    initial begin
        {arst_n, downloading, ioctl_wr, main_cs, char_cs, scr_cs} = '0;
        {ioctl_addr, ioctl_dout, main_addr, char_addr, scr_addr} = '0;
        {sdram_ack, data_rdy, data_read, req_prev} = '0;
        cycles    = 0;
        req_count = 0;
        for (int i = 0; i < 65536; i++) begin
            sdram_mem[i] = 16'(i) ^ 16'h3c5a;  // Fill follows the address
            ref_mem[i]   = 16'(i) ^ 16'h3c5a;
        end
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
        run_download(1'b0);
        repeat (fetch_rounds) fetch_round(3'(rand_bits(3)));
        cache_check();
        run_download(1'b1);  // Slots stay selected across the download
        settle_slots();
        repeat (fetch_rounds) fetch_round(3'(rand_bits(3)));
        if (i_rom_sys_top.i_props.assert_fails == 0) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            $display("A concurrent assertion failed during the run");
            $display("TEST FAILED");
            $fatal(1, "Assertion failures");
        end
    end

endmodule

`default_nettype wire

/* rom_sys_top.sv */
`timescale 1ns/10ps
`default_nettype none

module rom_sys_top
    import rom_pkg::*;
(
    input  wire                   clk,
    input  wire                   arst_n,
    // Loader
    input  wire                   downloading,
    input  wire  [ioctl_aw-1:0]   ioctl_addr,
    input  wire  [7:0]            ioctl_dout,
    input  wire                   ioctl_wr,
    // SDRAM write side
    output logic [sdram_aw-1:0]   prog_addr,
    output logic [7:0]            prog_data,
    output logic [1:0]            prog_mask,
    output logic                  prog_we,
    output logic [prom_count-1:0] prom_we,
    output logic [7:0]            game_cfg,
    // Fetch clients
    input  wire                   main_cs,
    input  wire  [main_aw-1:0]    main_addr,
    output logic                  main_ok,
    output logic [15:0]           main_dout,
    input  wire                   char_cs,
    input  wire  [char_aw-1:0]    char_addr,
    output logic                  char_ok,
    output logic [15:0]           char_dout,
    input  wire                   scr_cs,
    input  wire  [scr_aw-1:0]     scr_addr,
    output logic                  scr_ok,
    output logic [15:0]           scr_dout,
    // SDRAM read side
    output logic                  sdram_req,
    output logic [sdram_aw-1:0]   sdram_addr,
    input  wire                   sdram_ack,
    input  wire                   data_rdy,
    input  wire  [15:0]           data_read
);

    wire swab;  // From header byte 0

    header_regs i_header_regs (
        .clk         ( clk         ),
        .arst_n      ( arst_n      ),
        .downloading ( downloading ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_dout  ( ioctl_dout  ),
        .ioctl_wr    ( ioctl_wr    ),
        .swab        ( swab        ),
        .game_cfg    ( game_cfg    )
    );

    dwnld_remap i_dwnld_remap (
        .clk         ( clk         ),
        .arst_n      ( arst_n      ),
        .downloading ( downloading ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_dout  ( ioctl_dout  ),
        .ioctl_wr    ( ioctl_wr    ),
        .swab        ( swab        ),
        .prog_addr   ( prog_addr   ),
        .prog_data   ( prog_data   ),
        .prog_mask   ( prog_mask   ),  // Active low
        .prog_we     ( prog_we     ),
        .prom_we     ( prom_we     )
    );

    rom_slot_arb i_rom_slot_arb (
        .clk         ( clk         ),
        .arst_n      ( arst_n      ),
        .downloading ( downloading ),
        .main_cs     ( main_cs     ),
        .main_addr   ( main_addr   ),
        .main_ok     ( main_ok     ),
        .main_dout   ( main_dout   ),
        .char_cs     ( char_cs     ),
        .char_addr   ( char_addr   ),
        .char_ok     ( char_ok     ),
        .char_dout   ( char_dout   ),
        .scr_cs      ( scr_cs      ),  // Reads the scroll map region
        .scr_addr    ( scr_addr    ),
        .scr_ok      ( scr_ok      ),
        .scr_dout    ( scr_dout    ),
        .sdram_req   ( sdram_req   ),
        .sdram_addr  ( sdram_addr  ),
        .sdram_ack   ( sdram_ack   ),
        .data_rdy    ( data_rdy    ),
        .data_read   ( data_read   )
    );

endmodule

`default_nettype wire
